// ==== logic/dma_pkg.sv ====
/* types shared by the DMA engine blocks
   device codes are {ctrl[7], ctrl[2:0]}; codes not listed here run as plain RAM copy */

package dma_pkg;

  localparam int addr_w = 21;  // DRAM word address
  localparam int len_w  = 8;   // burst length and burst count

  // bit 3 set means RAM to device
  typedef enum logic [3:0] {
    dev_ram    = 4'b0001,
    dev_blt    = 4'b1001,  // transparent blit
    dev_fil    = 4'b0100,
    dev_spi_rd = 4'b0010,
    dev_spi_wr = 4'b1010
  } dma_dev_e;

  // one-cycle port write strobes from the CPU decoder
  typedef struct packed {
    logic saddr_l;
    logic saddr_h;
    logic saddr_x;
    logic daddr_l;
    logic daddr_h;
    logic daddr_x;
    logic len;
    logic launch;  // control byte write
    logic num;
  } dma_port_wr_t;

  typedef struct packed {
    dma_dev_e dev;
    logic     salgn;  // source rectangle
    logic     dalgn;  // destination rectangle
    logic     asz;    // 1: byte pixels, 256-word rows
  } dma_ctrl_t;

  // sequencer state seen by datapath and address generators
  typedef struct packed {
    logic rd;
    logic wr;
    logic blt_dst;     // blit reading destination
    logic bsel;        // high byte of SPI word
    logic next_burst;  // current word closes the burst
  } dma_phase_t;

endpackage

// ==== logic/dma_regs.sv ====
/* burst length and count are plain registers, written at any time
   launch leaves one cycle after the control byte strobe, together with ctrl */

`timescale 1ns/1ps

module dma_regs (
  input  logic                      clk,
  input  logic                      rst_n,
  input  dma_pkg::dma_port_wr_t     port_wr,
  input  logic [7:0]                zdata,
  output dma_pkg::dma_ctrl_t        ctrl,
  output logic [dma_pkg::len_w-1:0] b_len,
  output logic [dma_pkg::len_w-1:0] b_num,
  output logic                      launch
);

  import dma_pkg::*;

  logic [3:0] dev_code;
  dma_dev_e   dev_map;

  assign dev_code = {zdata[7], zdata[2:0]};  // direction + device

  always_comb
  begin
    case (dev_code)
      dev_blt, dev_fil, dev_spi_rd, dev_spi_wr: dev_map = dma_dev_e'(dev_code);
      default:                                  dev_map = dev_ram;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      ctrl   <= '{dev: dev_ram, salgn: 1'b0, dalgn: 1'b0, asz: 1'b0};
      launch <= 1'b0;
    end
    else
    begin
      launch <= port_wr.launch;
      if (port_wr.launch)
      begin
        ctrl.dev   <= dev_map;
        ctrl.salgn <= zdata[5];
        ctrl.dalgn <= zdata[4];
        ctrl.asz   <= zdata[3];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (port_wr.len)
      b_len <= zdata;  // words per burst minus one
    if (port_wr.num)
      b_num <= zdata;  // bursts minus one
  end

  // the port decoder hands over one register write per cycle
  a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(port_wr));

endmodule

// ==== logic/dma_addr_gen.sv ====
/* rectangle mode wraps the column inside the row and steps the row at burst end
   address bytes must not be written while a transfer steps this address */

`timescale 1ns/1ps

module dma_addr_gen (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       ld_l,
  input  logic                       ld_h,
  input  logic                       ld_x,
  input  logic [7:0]                 zdata,
  input  logic                       step,
  input  logic                       algn,
  input  logic                       asz,
  input  logic                       next_burst,
  output logic [dma_pkg::addr_w-1:0] addr
);

  import dma_pkg::*;

  logic [7:0]        row_start;  // column restored at row change
  logic [addr_w-1:0] addr_nx;

  always_comb
  begin
    addr_nx = addr + addr_w'(1);  // linear
    if (algn)
    begin
      if (asz)
      begin
        // 256-word rows
        addr_nx[7:0]        = next_burst ? row_start : addr[7:0] + 8'd1;
        addr_nx[addr_w-1:8] = addr[addr_w-1:8] + (addr_w-8)'(next_burst);
      end
      else
      begin
        // 128-word rows
        addr_nx[6:0]        = next_burst ? row_start[6:0] : addr[6:0] + 7'd1;
        addr_nx[addr_w-1:7] = addr[addr_w-1:7] + (addr_w-7)'(next_burst);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      addr <= '0;
    else if (step)
      addr <= addr_nx;
    else
    begin
      if (ld_l)
      begin
        addr[6:0]      <= zdata[7:1];  // byte address to word address
        row_start[6:0] <= zdata[7:1];
      end
      if (ld_h)
      begin
        addr[12:7]   <= zdata[5:0];
        row_start[7] <= zdata[0];
      end
      if (ld_x)
        addr[20:13] <= zdata;
    end
  end

  // CPU writes to an address register that is being stepped would be lost
  a_no_load_on_step: assert property (@(posedge clk) disable iff (!rst_n)
    step |-> !(ld_l || ld_h || ld_x));

endmodule

// ==== logic/dma_seq.sv ====
/* a new launch restarts the sequencer even when a transfer is running
   SPI words take two strobes, low byte first; fill reads once, then only writes */

`timescale 1ns/1ps

module dma_seq (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      launch,
  input  dma_pkg::dma_ctrl_t        ctrl,
  input  logic [dma_pkg::len_w-1:0] b_len,
  input  logic [dma_pkg::len_w-1:0] b_num,
  input  logic                      dram_next,
  input  logic                      spi_stb,
  output dma_pkg::dma_phase_t       phase,
  output logic                      s_step,
  output logic                      d_step,
  output logic                      src_sel,
  output logic                      dram_req,
  output logic                      dram_rnw,
  output logic                      spi_req,
  output logic                      dma_act,
  output logic                      int_start
);

  import dma_pkg::*;

  logic             phase_wr;  // 0 read, 1 write
  logic             blt_dst;   // 0 source, 1 destination
  logic             bsel;      // 0 low byte, 1 high byte
  logic [len_w-1:0] b_ctr;     // words left in burst
  logic [len_w:0]   n_ctr;     // bursts left, msb set when idle
  logic             act_q;

  logic dv_blt;
  logic dv_fil;
  logic dv_spi;
  logic spi_wnr;
  logic state_mem;
  logic state_dev;
  logic mem_done;
  logic byte_stb;
  logic dev_done;
  logic blt_hook;
  logic fil_hook;
  logic phase_end;
  logic word_done;
  logic last_in_burst;

  assign dv_blt  = (ctrl.dev == dev_blt);
  assign dv_fil  = (ctrl.dev == dev_fil);
  assign spi_wnr = (ctrl.dev == dev_spi_wr);
  assign dv_spi  = (ctrl.dev == dev_spi_rd) || spi_wnr;

  // SPI read uses the device in its read phase and SPI write in its write phase
  assign state_mem = !dv_spi || (spi_wnr ^ phase_wr);
  assign state_dev = !state_mem;

  assign mem_done  = dma_act && state_mem && dram_next;
  assign byte_stb  = dma_act && state_dev && spi_stb;
  assign dev_done  = byte_stb && bsel;   // high byte closes the word

  // blit source read does not end the read phase
  assign blt_hook  = dv_blt && !blt_dst && !phase_wr;
  assign fil_hook  = dv_fil && phase_wr;  // fill stays writing
  assign phase_end = (mem_done && !blt_hook) || dev_done;
  assign word_done = phase_wr && phase_end;

  assign last_in_burst = (b_ctr == '0);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      phase_wr <= 1'b0;
      blt_dst  <= 1'b0;
      bsel     <= 1'b0;
      b_ctr    <= '0;
      n_ctr    <= {1'b1, {len_w{1'b0}}};
      act_q    <= 1'b0;
    end
    else
    begin
      act_q <= dma_act;
      if (launch)
      begin
        phase_wr <= 1'b0;
        blt_dst  <= 1'b0;
        bsel     <= 1'b0;
        b_ctr    <= b_len;
        n_ctr    <= {1'b0, b_num};
      end
      else
      begin
        if (phase_end && !fil_hook)
          phase_wr <= !phase_wr;
        if (dv_blt && mem_done && !phase_wr)
          blt_dst <= !blt_dst;
        if (byte_stb)
          bsel <= !bsel;
        if (word_done)
        begin
          b_ctr <= last_in_burst ? b_len : b_ctr - len_w'(1);
          n_ctr <= n_ctr - (len_w+1)'(last_in_burst);  // underflow ends transfer
        end
      end
    end
  end

  always_comb
  begin
    phase.rd         = !phase_wr;
    phase.wr         = phase_wr;
    phase.blt_dst    = blt_dst;
    phase.bsel       = bsel;
    phase.next_burst = last_in_burst;
  end

  assign dma_act   = !n_ctr[len_w];
  assign int_start = act_q && !dma_act;

  assign dram_req = dma_act && state_mem;
  assign dram_rnw = !phase_wr;
  assign spi_req  = dma_act && state_dev;

  assign src_sel = !phase_wr && !blt_dst;
  assign s_step  = (mem_done || dev_done) && !phase_wr && !blt_dst;
  assign d_step  = word_done;

  a_req_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(dram_req && spi_req));

  // interrupt only once the last word of the last burst is written
  a_int_at_end: assert property (@(posedge clk) disable iff (!rst_n)
    int_start |-> !dma_act && $past(word_done && last_in_burst && (n_ctr == '0)));

endmodule

// ==== logic/dma_datapath.sv ====
/* the blit keeps the source word here and merges it into the destination read
   a zero nibble or byte of the source is transparent */

`timescale 1ns/1ps

module dma_datapath (
  input  logic                clk,
  input  logic                rst_n,
  input  dma_pkg::dma_ctrl_t  ctrl,
  input  dma_pkg::dma_phase_t phase,
  input  logic [15:0]         dram_rddata,
  input  logic                dram_next,
  input  logic [7:0]          spi_rddata,
  input  logic                spi_stb,
  output logic [15:0]         data,
  output logic [7:0]          spi_wrdata
);

  import dma_pkg::*;

  logic [15:0] blt_word;
  logic        dev_rd;
  logic        blt_sel;
  logic        mem_cap;
  logic        spi_cap;

  assign dev_rd  = (ctrl.dev == dev_spi_rd);
  assign blt_sel = (ctrl.dev == dev_blt) && phase.blt_dst;
  assign mem_cap = phase.rd && dram_next && !dev_rd;
  assign spi_cap = phase.rd && spi_stb && dev_rd;

  always_comb
  begin
    for (int i = 0; i < 4; i++)
    begin
      blt_word[i*4 +: 4] = (data[i*4 +: 4] != 4'h0) ? data[i*4 +: 4]
                                                    : dram_rddata[i*4 +: 4];
    end
    if (ctrl.asz)
    begin
      // byte pixels
      for (int i = 0; i < 2; i++)
      begin
        blt_word[i*8 +: 8] = (data[i*8 +: 8] != 8'h00) ? data[i*8 +: 8]
                                                       : dram_rddata[i*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      data <= '0;
    else if (mem_cap)
      data <= blt_sel ? blt_word : dram_rddata;
    else if (spi_cap)
    begin
      if (phase.bsel)
        data[15:8] <= spi_rddata;
      else
        data[7:0] <= spi_rddata;
    end
  end

  // device reads clock out 0xFF
  assign spi_wrdata = {8{phase.rd}} | (phase.bsel ? data[15:8] : data[7:0]);

endmodule

// ==== logic/dma_top.sv ====
/* DRAM and SPI answer with one-cycle dram_next / spi_stb while their request is high
   only one CPU strobe per cycle */

`timescale 1ns/1ps

module dma_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  dma_pkg::dma_port_wr_t      port_wr,
  input  logic [7:0]                 zdata,
  output logic [dma_pkg::addr_w-1:0] dram_addr,
  output logic [15:0]                dram_wrdata,
  output logic                       dram_req,
  output logic                       dram_rnw,
  input  logic [15:0]                dram_rddata,
  input  logic                       dram_next,
  output logic [7:0]                 spi_wrdata,
  output logic                       spi_req,
  input  logic [7:0]                 spi_rddata,
  input  logic                       spi_stb,
  output logic                       dma_act,
  output logic                       int_start
);

  import dma_pkg::*;

  dma_ctrl_t         ctrl;
  dma_phase_t        phase;
  logic [len_w-1:0]  b_len;
  logic [len_w-1:0]  b_num;
  logic              launch;
  logic [addr_w-1:0] s_addr;
  logic [addr_w-1:0] d_addr;
  logic              s_step;
  logic              d_step;
  logic              src_sel;

  dma_regs u_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .port_wr (port_wr),
    .zdata   (zdata),
    .ctrl    (ctrl),
    .b_len   (b_len),
    .b_num   (b_num),
    .launch  (launch)
  );

  dma_addr_gen u_src (
    .clk        (clk),
    .rst_n      (rst_n),
    .ld_l       (port_wr.saddr_l),
    .ld_h       (port_wr.saddr_h),
    .ld_x       (port_wr.saddr_x),
    .zdata      (zdata),
    .step       (s_step),
    .algn       (ctrl.salgn),
    .asz        (ctrl.asz),
    .next_burst (phase.next_burst),
    .addr       (s_addr)
  );

  dma_addr_gen u_dst (
    .clk        (clk),
    .rst_n      (rst_n),
    .ld_l       (port_wr.daddr_l),
    .ld_h       (port_wr.daddr_h),
    .ld_x       (port_wr.daddr_x),
    .zdata      (zdata),
    .step       (d_step),
    .algn       (ctrl.dalgn),
    .asz        (ctrl.asz),
    .next_burst (phase.next_burst),
    .addr       (d_addr)
  );

  dma_seq u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .launch    (launch),
    .ctrl      (ctrl),
    .b_len     (b_len),
    .b_num     (b_num),
    .dram_next (dram_next),
    .spi_stb   (spi_stb),
    .phase     (phase),
    .s_step    (s_step),
    .d_step    (d_step),
    .src_sel   (src_sel),
    .dram_req  (dram_req),
    .dram_rnw  (dram_rnw),
    .spi_req   (spi_req),
    .dma_act   (dma_act),
    .int_start (int_start)
  );

  dma_datapath u_data (
    .clk         (clk),
    .rst_n       (rst_n),
    .ctrl        (ctrl),
    .phase       (phase),
    .dram_rddata (dram_rddata),
    .dram_next   (dram_next),
    .spi_rddata  (spi_rddata),
    .spi_stb     (spi_stb),
    .data        (dram_wrdata),
    .spi_wrdata  (spi_wrdata)
  );

  assign dram_addr = src_sel ? s_addr : d_addr;  // source only in its read phase

endmodule

// ==== bench/dma_tb_clk.sv ====
/* 4 ns clock, rst_n released 1 ns after the third rising edge */

`timescale 1ns/1ps

module dma_tb_clk (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #2 clk = !clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

// ==== bench/dma_tb_mem.sv ====
/* DRAM answers each request after 2 to 5 cycles, SPI strobes after the same spread
   SPI read bytes come from rx_q, every byte clocked out is kept in tx_q */

`timescale 1ns/1ps

module dma_tb_mem (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [dma_pkg::addr_w-1:0] dram_addr,
  input  logic [15:0]                dram_wrdata,
  input  logic                       dram_req,
  input  logic                       dram_rnw,
  output logic [15:0]                dram_rddata,
  output logic                       dram_next,
  input  logic [7:0]                 spi_wrdata,
  input  logic                       spi_req,
  output logic [7:0]                 spi_rddata,
  output logic                       spi_stb
);

  import dma_pkg::*;

  logic [15:0] mem [logic [addr_w-1:0]];  // sparse
  logic [7:0]  rx_q [$];
  logic [7:0]  tx_q [$];
  int          seed;
  int          mem_wait;  // -1 when no request is being timed
  int          spi_wait;
  int          rd_count;

  function automatic logic [15:0] peek(input logic [addr_w-1:0] a);
    if (mem.exists(a))
      return mem[a];
    return a[15:0] ^ {a[20:16], 11'h35a};  // never written
  endfunction

  task automatic poke(input logic [addr_w-1:0] a, input logic [15:0] v);
    mem[a] = v;
  endtask

  task automatic push_rx(input logic [7:0] b);
    rx_q.push_back(b);
  endtask

  function automatic int tx_count();
    return tx_q.size();
  endfunction

  function automatic logic [7:0] tx_byte(input int i);
    return tx_q[i];
  endfunction

  initial
  begin
    seed        = 55519;
    mem_wait    = -1;
    spi_wait    = -1;
    rd_count    = 0;
    dram_next   = 1'b0;
    dram_rddata = '0;
    spi_stb     = 1'b0;
    spi_rddata  = '0;
    forever
    begin
      @(posedge clk);
      #1;
      dram_next = 1'b0;
      spi_stb   = 1'b0;
      if (rst_n && dram_req)
      begin
        if (mem_wait < 0)
          mem_wait = 2 + int'($unsigned($random(seed)) % 4);
        mem_wait--;
        if (mem_wait == 0)
        begin
          dram_next = 1'b1;
          if (dram_rnw)
          begin
            dram_rddata = peek(dram_addr);
            rd_count++;
          end
          else
            mem[dram_addr] = dram_wrdata;
          mem_wait = -1;
        end
      end
      else
        mem_wait = -1;
      if (rst_n && spi_req)
      begin
        if (spi_wait < 0)
          spi_wait = 2 + int'($unsigned($random(seed)) % 4);
        spi_wait--;
        if (spi_wait == 0)
        begin
          spi_stb = 1'b1;
          if (rx_q.size() > 0)
            spi_rddata = rx_q.pop_front();
          else
            spi_rddata = 8'h00;
          tx_q.push_back(spi_wrdata);  // what the device saw
          spi_wait = -1;
        end
      end
      else
        spi_wait = -1;
    end
  end

endmodule

// ==== bench/dma_tb.sv ====
/* checks are concurrent assertions fed by the stimulus; memory is compared after int_start
   inputs change 1 ns after the rising edge; a cycle limit ends a hung run */

`timescale 1ns/1ps

module dma_tb;

  import dma_pkg::*;

  localparam int total_words = 84;  // words moved by all tests
  localparam int cycle_limit = total_words * 3 * 5 + 2000;

  logic              clk;
  logic              rst_n;
  dma_port_wr_t      port_wr;
  logic [7:0]        zdata;
  logic [addr_w-1:0] dram_addr;
  logic [15:0]       dram_wrdata;
  logic [15:0]       dram_rddata;
  logic              dram_req;
  logic              dram_rnw;
  logic              dram_next;
  logic [7:0]        spi_wrdata;
  logic [7:0]        spi_rddata;
  logic              spi_req;
  logic              spi_stb;
  logic              dma_act;
  logic              int_start;

  logic [15:0] ref_img [logic [addr_w-1:0]];  // what the DRAM should hold
  int          tb_seed;
  int          errors;
  int          err_mark;
  int          tests_run;
  int          tests_failed;
  int          cycles = 0;
  logic        chk_en;
  logic [15:0] chk_got;
  logic [15:0] chk_exp;
  string       chk_name;
  logic        spi_rd_mode;

  dma_tb_clk u_clk (.clk(clk), .rst_n(rst_n));

  dma_tb_mem u_mem (
    .clk(clk), .rst_n(rst_n), .dram_addr(dram_addr), .dram_wrdata(dram_wrdata),
    .dram_req(dram_req), .dram_rnw(dram_rnw), .dram_rddata(dram_rddata),
    .dram_next(dram_next), .spi_wrdata(spi_wrdata), .spi_req(spi_req),
    .spi_rddata(spi_rddata), .spi_stb(spi_stb)
  );

  dma_top u_dut (
    .clk(clk), .rst_n(rst_n), .port_wr(port_wr), .zdata(zdata), .dram_addr(dram_addr),
    .dram_wrdata(dram_wrdata), .dram_req(dram_req), .dram_rnw(dram_rnw),
    .dram_rddata(dram_rddata), .dram_next(dram_next), .spi_wrdata(spi_wrdata),
    .spi_req(spi_req), .spi_rddata(spi_rddata), .spi_stb(spi_stb),
    .dma_act(dma_act), .int_start(int_start)
  );

  a_value: assert property (@(posedge clk) chk_en |-> chk_got == chk_exp)
  else
  begin
    errors++;
    $display("MISMATCH %s got 0x%h expected 0x%h", chk_name, chk_got, chk_exp);
  end

  a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |->
    !(dma_act || dram_req || spi_req || int_start))
  else
  begin
    errors++;
    $display("DUT outputs were not idle after reset");
  end

  a_int_follows: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(dma_act) |-> int_start)
  else
  begin
    errors++;
    $display("int_start did not follow the fall of dma_act");
  end

  a_int_single: assert property (@(posedge clk) disable iff (!rst_n)
    int_start |-> !dma_act ##1 !int_start)
  else
  begin
    errors++;
    $display("int_start was not a single cycle pulse after dma_act");
  end

  // device reads clock out all ones
  a_spi_rd_ff: assert property (@(posedge clk) disable iff (!rst_n)
    (spi_rd_mode && spi_stb) |-> spi_wrdata == 8'hff)
  else
  begin
    errors++;
    $display("MISMATCH spi_wrdata got 0x%h expected 0xff", spi_wrdata);
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic preset(input logic [20:0] a, input logic [15:0] v);
    u_mem.poke(a, v);
    ref_img[a] = v;
  endtask

  task automatic expect_word(input string name, input logic [15:0] got, input logic [15:0] exp);
    chk_name = name;
    chk_got  = got;
    chk_exp  = exp;
    chk_en   = 1'b1;
    @(posedge clk);
    #1 chk_en = 1'b0;
  endtask

  task automatic cpu_write(input dma_port_wr_t stb, input logic [7:0] val);
    port_wr = stb;
    zdata   = val;
    @(posedge clk);
    #1 port_wr = '0;
  endtask

  task automatic load_addr(input logic src, input logic [20:0] a);
    dma_port_wr_t s;
    s = '0;
    s.saddr_l = src;
    s.daddr_l = !src;
    cpu_write(s, {a[6:0], 1'b0});  // byte address
    s = '0;
    s.saddr_h = src;
    s.daddr_h = !src;
    cpu_write(s, {2'b00, a[12:7]});
    s = '0;
    s.saddr_x = src;
    s.daddr_x = !src;
    cpu_write(s, a[20:13]);
  endtask

  task automatic run_transfer(input logic [7:0] len, input logic [7:0] num,
                              input logic [7:0] ctl, input logic [20:0] src,
                              input logic [20:0] dst);
    dma_port_wr_t s;
    load_addr(1'b1, src);
    load_addr(1'b0, dst);
    s = '0;
    s.len = 1'b1;
    cpu_write(s, len);
    s = '0;
    s.num = 1'b1;
    cpu_write(s, num);
    s = '0;
    s.launch = 1'b1;
    cpu_write(s, ctl);
    while (int_start !== 1'b1)
    begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
  endtask

  // word k,j of a block; row 0 is linear
  function automatic logic [20:0] blk_addr(input logic [20:0] base, input int k, input int j,
                                           input int len, input int row);
    int stride;
    stride = (row == 0) ? len + 1 : row;
    return base + 21'(k * stride + j);
  endfunction

  function automatic logic [15:0] blit_merge(input logic [15:0] s, input logic [15:0] d,
                                             input logic asz);
    logic [15:0] r;
    r = d;
    for (int n = 0; n < 4; n++)
    begin
      if (!asz && s[n*4 +: 4] != 4'h0)
        r[n*4 +: 4] = s[n*4 +: 4];
      if (asz && n < 2 && s[n*8 +: 8] != 8'h00)
        r[n*8 +: 8] = s[n*8 +: 8];
    end
    return r;
  endfunction

  task automatic run_copy(input logic [20:0] src, input logic [20:0] dst, input int len,
                          input int num, input logic [7:0] ctl, input int row);
    logic [20:0] g;
    for (int k = 0; k <= num; k++)
    begin
      for (int j = 0; j <= len; j++)
      begin
        preset(blk_addr(src, k, j, len, row), 16'($random(tb_seed)));
        preset(blk_addr(dst, k, j, len, row), 16'hdead);
      end
      if (row != 0 || k == num)
        preset(blk_addr(dst, k, len + 1, len, row), 16'hbeef);  // just past the row
    end
    preset(dst - 21'd1, 16'hbeef);
    run_transfer(8'(len), 8'(num), ctl, src, dst);
    for (int k = 0; k <= num; k++)
    begin
      for (int j = 0; j <= len; j++)
      begin
        g = blk_addr(dst, k, j, len, row);
        expect_word($sformatf("dram[%h]", g), u_mem.peek(g),
                    ref_img[blk_addr(src, k, j, len, row)]);
      end
      if (row != 0 || k == num)
      begin
        g = blk_addr(dst, k, len + 1, len, row);
        expect_word($sformatf("dram[%h]", g), u_mem.peek(g), ref_img[g]);
      end
    end
    expect_word("dram[dst-1]", u_mem.peek(dst - 21'd1), ref_img[dst - 21'd1]);
  endtask

  task automatic run_blit(input logic asz);
    logic [15:0] s;
    logic [15:0] m;
    for (int i = 0; i < 8; i++)
    begin
      s = 16'($random(tb_seed));
      m = 16'($random(tb_seed));
      for (int n = 0; n < 4; n++)
        if (m[n])
          s[n*4 +: 4] = 4'h0;  // transparent pixels
      for (int n = 0; n < 2; n++)
        if (m[n+4])
          s[n*8 +: 8] = 8'h00;
      preset(21'h14000 + 21'(i), s);
      preset(21'h15000 + 21'(i), 16'($random(tb_seed)));
    end
    run_transfer(8'd3, 8'd1, {4'h8, asz, 3'b001}, 21'h14000, 21'h15000);
    for (int i = 0; i < 8; i++)
      expect_word($sformatf("blit dram[%0d]", i), u_mem.peek(21'h15000 + 21'(i)),
                  blit_merge(ref_img[21'h14000 + 21'(i)], ref_img[21'h15000 + 21'(i)], asz));
  endtask

  task automatic run_fill();
    int rd0;
    preset(21'h16000, 16'h5ac3);
    for (int i = 0; i < 10; i++)
      preset(21'h16100 + 21'(i), 16'h0000);
    rd0 = u_mem.rd_count;
    run_transfer(8'd4, 8'd1, 8'h04, 21'h16000, 21'h16100);
    expect_word("dram read count", 16'(u_mem.rd_count - rd0), 16'd1);
    for (int i = 0; i < 10; i++)
      expect_word($sformatf("fill dram[%0d]", i), u_mem.peek(21'h16100 + 21'(i)), 16'h5ac3);
  endtask

  task automatic run_spi_read();
    logic [7:0] rx [16];
    for (int i = 0; i < 16; i++)
    begin
      rx[i] = 8'($random(tb_seed));
      u_mem.push_rx(rx[i]);
    end
    spi_rd_mode = 1'b1;
    run_transfer(8'd3, 8'd1, 8'h02, 21'h0, 21'h17000);
    spi_rd_mode = 1'b0;
    for (int i = 0; i < 8; i++)
      expect_word($sformatf("spi read dram[%0d]", i), u_mem.peek(21'h17000 + 21'(i)),
                  {rx[2*i+1], rx[2*i]});  // low byte first
  endtask

  task automatic run_spi_write();
    int tx0;
    for (int i = 0; i < 8; i++)
      preset(21'h17100 + 21'(i), 16'($random(tb_seed)));
    tx0 = u_mem.tx_count();
    run_transfer(8'd3, 8'd1, 8'h82, 21'h17100, 21'h17200);
    expect_word("spi byte count", 16'(u_mem.tx_count() - tx0), 16'd16);
    for (int i = 0; i < 8; i++)
    begin
      expect_word($sformatf("spi_wrdata[%0d]", 2*i), {8'h00, u_mem.tx_byte(tx0 + 2*i)},
                  {8'h00, ref_img[21'h17100 + 21'(i)][7:0]});
      expect_word($sformatf("spi_wrdata[%0d]", 2*i+1), {8'h00, u_mem.tx_byte(tx0 + 2*i + 1)},
                  {8'h00, ref_img[21'h17100 + 21'(i)][15:8]});
    end
  endtask

  task automatic report(input string name);
    tests_run++;
    if (errors != err_mark)
    begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, errors - err_mark);
    end
    else
      $display("test %0d %s: ok", tests_run, name);
    err_mark = errors;
  endtask

  initial
  begin
    tb_seed      = 55519;
    errors       = 0;
    err_mark     = 0;
    tests_run    = 0;
    tests_failed = 0;
    port_wr      = '0;
    zdata        = '0;
    chk_en       = 1'b0;
    chk_got      = '0;
    chk_exp      = '0;
    chk_name     = "";
    spi_rd_mode  = 1'b0;
    @(posedge rst_n);
    repeat (3)
    begin
      @(posedge clk);
      #1;
    end
    report("reset and interrupt");
    run_copy(21'h1a230, 21'h05548, 5, 2, 8'h01, 0);
    report("linear copy");
    run_copy(21'h04010, 21'h08020, 3, 2, 8'h31, 128);
    run_copy(21'h0c010, 21'h10020, 3, 2, 8'h39, 256);
    report("rectangle copy");
    run_blit(1'b0);
    run_blit(1'b1);
    report("transparent blit");
    run_fill();
    report("fill");
    run_spi_read();
    report("spi read");
    run_spi_write();
    report("spi write");
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// ==== src.f ====
logic/dma_pkg.sv
logic/dma_regs.sv
logic/dma_addr_gen.sv
logic/dma_seq.sv
logic/dma_datapath.sv
logic/dma_top.sv
bench/dma_tb_clk.sv
bench/dma_tb_mem.sv
bench/dma_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the DMA testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module dma_tb -o sim_dma
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_dma > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Regression passed$" sim.log; then
  exit 0
fi
echo "pass line not found in sim.log"
exit 1
